//--- sim.f
common/camera_pkg.sv
verilog/command_decoder.sv
verilog/pwm_bank.sv
mcp3008/mcp3008_interface.sv
verilog/tx_framer.sv
verilog/camera_ctrl_top.sv
tb/mcp3008_model.sv
tb/camera_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the camera control testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 -f sim.f \
      --top-module camera_ctrl_tb -o camera_ctrl_sim; then
   echo "verilator build failed"
   exit 1
fi

if ! output=$(./obj_dir/camera_ctrl_sim 2>&1); then
   echo "$output"
   echo "simulation exited with an error status"
   exit 1
fi
echo "$output"

if grep -q "TESTBENCH PASSED" <<< "$output"; then
   exit 0
fi
exit 1

//--- tb/camera_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module camera_ctrl_tb;

   localparam int dclk_half       = 2;
   localparam int adc_cycles      = 17 * 2 * dclk_half + 40; // conversion plus frame
   localparam int frame_cycles    = 40; // one readback request and its frame
   localparam int test1_cycles    = 200;
   localparam int test2_cycles    = 2 * 256 + 100;
   localparam int test3_cycles    = 2 * 65536 + 100;
   localparam int test4_cycles    = 4 * adc_cycles;
   localparam int test5_cycles    = 2 * adc_cycles + 256 + 200;
   localparam int watchdog_cycles = 8 + test1_cycles + test2_cycles + test3_cycles
                                    + test4_cycles + test5_cycles + 1000;

   logic       clk;
   logic       reset;
   logic       rx_strobe;
   logic [7:0] rx_data;
   logic       tx_strobe;
   logic [7:0] tx_data;
   logic       mcp_dout;
   logic       mcp_dclk;
   logic       mcp_din;
   logic       mcp_cs_n;
   logic       pwm_peltier_1;
   logic       pwm_peltier_2;
   logic       pwm_shutter;
   logic [9:0] value_for_channel;
   logic [2:0] channel_seen;

   integer      seed;
   int          errors;
   int          checks;
   int          tests;
   int          err_at_start;
   logic [7:0]  ref_regs [0:3];   // address 3 stays zero
   logic [23:0] exp_q [$];        // header and reply word

   // frame monitor state
   logic [1:0]  byte_idx;
   logic [15:0] frame_acc;
   logic [23:0] frame_got;
   logic [23:0] frame_exp;
   logic        frame_ready;
   logic        frame_extra;
   logic        frame_gap;

   camera_ctrl_top #(.DCLK_HALF(dclk_half), .PWM_BITS(8)) uut (
      .clk(clk), .reset(reset),
      .rx_strobe(rx_strobe), .rx_data(rx_data), .mcp_dout(mcp_dout),
      .tx_strobe(tx_strobe), .tx_data(tx_data),
      .mcp_dclk(mcp_dclk), .mcp_din(mcp_din), .mcp_cs_n(mcp_cs_n),
      .pwm_peltier_1(pwm_peltier_1), .pwm_peltier_2(pwm_peltier_2),
      .pwm_shutter(pwm_shutter)
   );

   mcp3008_model adc_model (
      .cs_n(mcp_cs_n), .dclk(mcp_dclk), .din(mcp_din),
      .value_for_channel(value_for_channel),
      .dout(mcp_dout), .channel_seen(channel_seen)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   initial begin
      #(watchdog_cycles * 10);
      $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
      $display("TESTBENCH FAILED");
      $finish;
   end

   // collects tx bytes into frames on the falling edge
   always @(negedge clk) begin
      frame_ready <= 1'b0;
      frame_gap   <= 1'b0;
      if (reset) begin
         byte_idx <= 2'd0;
      end else if (tx_strobe) begin
         frame_acc <= {frame_acc[7:0], tx_data};
         if (byte_idx == 2'd2) begin
            byte_idx    <= 2'd0;
            frame_ready <= 1'b1;
            frame_got   <= {frame_acc, tx_data};
            frame_extra <= (exp_q.size() == 0);
            if (exp_q.size() != 0)
               frame_exp <= exp_q.pop_front();
            checks++;
         end else begin
            byte_idx <= byte_idx + 2'd1;
         end
      end else if (byte_idx != 2'd0) begin
         frame_gap <= 1'b1; // frame bytes must come back to back
         byte_idx  <= 2'd0;
      end
   end

   assert property (@(posedge clk) disable iff (reset) frame_ready |-> !frame_extra)
      else begin
         $display("frame 0x%06h arrived on tx while none was expected", frame_got);
         errors++;
      end

   assert property (@(posedge clk) disable iff (reset)
      frame_ready && !frame_extra |-> frame_got[23:16] == frame_exp[23:16])
      else begin
         $display("** Error: tx_data header got 0x%02h expected 0x%02h",
                  frame_got[23:16], frame_exp[23:16]);
         errors++;
      end

   assert property (@(posedge clk) disable iff (reset)
      frame_ready && !frame_extra |-> frame_got[15:0] == frame_exp[15:0])
      else begin
         $display("** Error: tx_data word got 0x%04h expected 0x%04h",
                  frame_got[15:0], frame_exp[15:0]);
         errors++;
      end

   assert property (@(posedge clk) disable iff (reset) !frame_gap)
      else begin
         $display("tx frame broken off before its third byte");
         errors++;
      end

   assert property (@(posedge clk) disable iff (reset) tx_strobe |-> mcp_cs_n)
      else begin
         $display("tx frame sent while the ADC chip select was still low");
         errors++;
      end

   function automatic logic [23:0] register_frame(input logic [1:0] a);
      return {camera_pkg::hdr_register, 6'b000000, a, ref_regs[a]};
   endfunction

   function automatic logic [23:0] adc_frame(input logic [2:0] ch);
      return {camera_pkg::hdr_adc, 1'b0, ch, 2'b00, value_for_channel};
   endfunction

   // called on a falling edge and returns on the next one
   task automatic send_byte(input logic [7:0] b);
      rx_strobe = 1'b1;
      rx_data   = b;
      @(negedge clk);
      rx_strobe = 1'b0;
   endtask

   task automatic write_reg(input logic [1:0] a, input logic [7:0] v);
      send_byte(camera_pkg::cmd_set_register);
      send_byte({6'b000000, a});
      send_byte(v);
      if (a != 2'd3)
         ref_regs[a] = v;
   endtask

   task automatic read_reg(input logic [1:0] a);
      exp_q.push_back(register_frame(a));
      send_byte(camera_pkg::cmd_read_register);
      send_byte({6'b000000, a});
   endtask

   task automatic sample_adc(input logic [2:0] ch);
      logic [4:0] junk;
      junk              = 5'($random(seed)); // upper bits of the channel byte are ignored
      value_for_channel = 10'($random(seed));
      exp_q.push_back(adc_frame(ch));
      send_byte(camera_pkg::cmd_sample_adc);
      send_byte({junk, ch});
   endtask

   task automatic wait_frames(input int limit);
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < limit) begin
         @(posedge clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         $display("%0d expected frame(s) missing on tx after %0d cycles", exp_q.size(), limit);
         errors++;
         exp_q.delete();
      end
      repeat (2) @(negedge clk);
   endtask

   task automatic count_high(input int cycles, output int n1, output int n2, output int ns);
      n1 = 0;
      n2 = 0;
      ns = 0;
      repeat (cycles) begin
         @(negedge clk);
         if (pwm_peltier_1) n1++;
         if (pwm_peltier_2) n2++;
         if (pwm_shutter)   ns++;
      end
   endtask

   task automatic check_value(input string name, input int got, input int exp);
      checks++;
      assert (got == exp)
         else begin
            $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
         end
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors == err_at_start)
         $display("test %0d %s: ok", tests, name);
      else
         $display("test %0d %s: %0d error(s)", tests, name, errors - err_at_start);
      err_at_start = errors;
   endtask

   initial begin
      int         n1;
      int         n2;
      int         ns;
      int         falls;
      logic       prev_dclk;
      logic [2:0] ch;
      seed              = 32'h299f;
      errors            = 0;
      checks            = 0;
      tests             = 0;
      err_at_start      = 0;
      reset             = 1'b1;
      rx_strobe         = 1'b0;
      rx_data           = 8'h00;
      value_for_channel = 10'h000;
      for (int a = 0; a < 4; a++)
         ref_regs[a] = 8'h00;
      repeat (8) @(negedge clk);
      reset = 1'b0;
      repeat (2) @(negedge clk);

      for (int a = 0; a < 4; a++)
         write_reg(2'(a), 8'($random(seed)));
      for (int a = 0; a < 4; a++) begin
         read_reg(2'(a));
         wait_frames(frame_cycles);
      end
      end_test("register write and readback");

      write_reg(camera_pkg::reg_peltier_1, 8'($random(seed)));
      write_reg(camera_pkg::reg_peltier_2, 8'($random(seed)));
      repeat (4) @(negedge clk);
      count_high(256, n1, n2, ns);
      check_value("pwm_peltier_1 high count", n1, int'(ref_regs[0]));
      check_value("pwm_peltier_2 high count", n2, int'(ref_regs[1]));
      end_test("peltier pwm");

      send_byte(camera_pkg::cmd_open_shutter);
      repeat (4) @(negedge clk);
      count_high(65536, n1, n2, ns);
      check_value("pwm_shutter open high count", ns, 32'h50 * 256);
      send_byte(camera_pkg::cmd_close_shutter);
      repeat (4) @(negedge clk);
      count_high(65536, n1, n2, ns);
      check_value("pwm_shutter closed high count", ns, 32'h96 * 256);
      end_test("shutter pwm");

      repeat (4) begin
         ch = 3'($random(seed));
         sample_adc(ch);
         wait_frames(adc_cycles);
         check_value("channel_seen", int'(channel_seen), int'(ch));
      end
      end_test("adc sample");

      // readback lands in the same cycle as the ADC result
      ch                = 3'($random(seed));
      value_for_channel = 10'($random(seed));
      exp_q.push_back(adc_frame(ch));
      exp_q.push_back(register_frame(camera_pkg::reg_spare));
      send_byte(camera_pkg::cmd_sample_adc);
      send_byte({5'b00000, ch});
      send_byte(camera_pkg::cmd_read_register);
      falls     = 0;
      prev_dclk = mcp_dclk;
      while (falls < 17) begin
         @(negedge clk);
         if (prev_dclk && !mcp_dclk)
            falls++;
         prev_dclk = mcp_dclk;
      end
      repeat (dclk_half - 1) @(negedge clk);
      send_byte({6'b000000, camera_pkg::reg_spare});
      wait_frames(adc_cycles);

      send_byte(camera_pkg::cmd_reset);
      for (int a = 0; a < 4; a++)
         ref_regs[a] = 8'h00;
      for (int a = 0; a < 3; a++) begin
         read_reg(2'(a));
         wait_frames(frame_cycles);
      end
      count_high(256, n1, n2, ns);
      check_value("pwm_peltier_1 high count after reset", n1, 0);
      check_value("pwm_peltier_2 high count after reset", n2, 0);

      send_byte(8'hFF); // not a command
      repeat (30) @(negedge clk);
      read_reg(camera_pkg::reg_peltier_1);
      wait_frames(frame_cycles);
      end_test("priority and reset");

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb/mcp3008_model.sv
`timescale 1ns/1ps
`default_nettype none

// behavioral MCP3008, single ended conversions only
// din is taken on rising dclk, dout changes on falling dclk
module mcp3008_model (
   input  wire logic       cs_n,
   input  wire logic       dclk,
   input  wire logic       din,
   input  wire logic [9:0] value_for_channel,
   output logic            dout,
   output logic [2:0]      channel_seen
);

   int         rise_cnt;
   int         fall_cnt;
   logic [4:0] cmd;         // start, sgl/diff, d2 d1 d0
   logic [9:0] out_shift;

   initial begin
      dout         = 1'b0;
      channel_seen = 3'd0;
      rise_cnt     = 0;
      fall_cnt     = 0;
   end

   always @(negedge cs_n) begin
      rise_cnt  = 0;
      fall_cnt  = 0;
      out_shift = value_for_channel; // result fixed when the device is selected
   end

   always @(posedge dclk) begin
      if (!cs_n) begin
         rise_cnt = rise_cnt + 1;
         if (rise_cnt <= 5)
            cmd = {cmd[3:0], din};
         if (rise_cnt == 5)
            channel_seen = cmd[2:0];
      end
   end

   // null bit on fall 7, then B9 first from fall 8
   always @(negedge dclk) begin
      if (!cs_n) begin
         fall_cnt = fall_cnt + 1;
         if (fall_cnt >= 8) begin
            dout      <= out_shift[9];
            out_shift = {out_shift[8:0], 1'b0};
         end else begin
            dout <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/camera_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module camera_ctrl_top #(
   parameter int DCLK_HALF = 4,
   parameter int PWM_BITS  = 8
) (
   input  wire logic       clk,
   input  wire logic       reset,
   input  wire logic       rx_strobe,
   input  wire logic [7:0] rx_data,
   input  wire logic       mcp_dout,
   output logic            tx_strobe,
   output logic [7:0]      tx_data,
   output logic            mcp_dclk,
   output logic            mcp_din,
   output logic            mcp_cs_n,
   output logic            pwm_peltier_1,
   output logic            pwm_peltier_2,
   output logic            pwm_shutter
);

   logic                               adc_start;
   logic [2:0]                         adc_channel;
   logic                               adc_busy;
   logic                               adc_result_valid;
   logic [camera_pkg::reply_width-1:0] adc_result;
   logic                               adc_result_accept;
   logic                               readback_valid;
   logic [camera_pkg::reply_width-1:0] readback_word;
   logic                               readback_accept;
   logic [7:0]                         peltier_1_duty;
   logic [7:0]                         peltier_2_duty;
   logic                               shutter_open;

   command_decoder u_decoder (
      .clk(clk), .reset(reset),
      .rx_strobe(rx_strobe), .rx_data(rx_data),
      .adc_busy(adc_busy), .readback_accept(readback_accept),
      .adc_start(adc_start), .adc_channel(adc_channel),
      .readback_valid(readback_valid), .readback_word(readback_word),
      .peltier_1_duty(peltier_1_duty), .peltier_2_duty(peltier_2_duty),
      .shutter_open(shutter_open)
   );

   pwm_bank #(.PWM_BITS(PWM_BITS)) u_pwm (
      .clk(clk), .reset(reset),
      .peltier_1_duty(peltier_1_duty), .peltier_2_duty(peltier_2_duty),
      .shutter_open(shutter_open),
      .pwm_peltier_1(pwm_peltier_1), .pwm_peltier_2(pwm_peltier_2),
      .pwm_shutter(pwm_shutter)
   );

   mcp3008_interface #(.DCLK_HALF(DCLK_HALF)) u_adc (
      .clk(clk), .reset(reset),
      .adc_start(adc_start), .adc_channel(adc_channel), .mcp_dout(mcp_dout),
      .mcp_dclk(mcp_dclk), .mcp_din(mcp_din), .mcp_cs_n(mcp_cs_n),
      .adc_busy(adc_busy), .adc_result_valid(adc_result_valid),
      .adc_result(adc_result), .adc_result_accept(adc_result_accept)
   );

   tx_framer u_framer (
      .clk(clk), .reset(reset),
      .adc_result_valid(adc_result_valid), .adc_result(adc_result),
      .readback_valid(readback_valid), .readback_word(readback_word),
      .adc_result_accept(adc_result_accept), .readback_accept(readback_accept),
      .tx_strobe(tx_strobe), .tx_data(tx_data)
   );

endmodule

`default_nettype wire

//--- verilog/tx_framer.sv
`timescale 1ns/1ps
`default_nettype none

// three byte frames: header, word high byte, word low byte
module tx_framer (
   input  wire logic                                clk,
   input  wire logic                                reset,
   input  wire logic                                adc_result_valid,
   input  wire logic [camera_pkg::reply_width-1:0]  adc_result,
   input  wire logic                                readback_valid,
   input  wire logic [camera_pkg::reply_width-1:0]  readback_word,
   output logic                                     adc_result_accept,
   output logic                                     readback_accept,
   output logic                                     tx_strobe,
   output logic [7:0]                               tx_data
);

   logic [1:0]                         byte_cnt;   // 0 idle, 1 high next, 2 low next
   logic [camera_pkg::reply_width-1:0] frame_word;
   logic                               idle;
   logic                               start;

   assign idle  = (byte_cnt == 2'd0);
   assign start = idle && (adc_result_valid || readback_valid);

   always_ff @(posedge clk) begin
      adc_result_accept <= 1'b0;
      readback_accept   <= 1'b0;
      tx_strobe         <= 1'b0;
      if (reset) begin
         byte_cnt <= 2'd0;
      end else begin
         case (byte_cnt)
            2'd0: begin
               if (adc_result_valid) begin
                  adc_result_accept <= 1'b1; // ADC result has priority
                  tx_strobe         <= 1'b1;
                  byte_cnt          <= 2'd1;
               end else if (readback_valid) begin
                  readback_accept <= 1'b1;
                  tx_strobe       <= 1'b1;
                  byte_cnt        <= 2'd1;
               end
            end
            2'd1: begin
               tx_strobe <= 1'b1;
               byte_cnt  <= 2'd2;
            end
            2'd2: begin
               tx_strobe <= 1'b1;
               byte_cnt  <= 2'd0; // ready again right after the low byte
            end
            default: byte_cnt <= 2'd0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         if (adc_result_valid) begin
            frame_word <= adc_result;
            tx_data    <= camera_pkg::hdr_adc;
         end else begin
            frame_word <= readback_word;
            tx_data    <= camera_pkg::hdr_register;
         end
      end else if (byte_cnt == 2'd1) begin
         tx_data <= frame_word[15:8];
      end else if (byte_cnt == 2'd2) begin
         tx_data <= frame_word[7:0];
      end
   end

   // only one source may be taken per frame
   assert property (@(posedge clk) disable iff (reset)
      !(adc_result_accept && readback_accept));

endmodule

`default_nettype wire

//--- mcp3008/mcp3008_interface.sv
`timescale 1ns/1ps
`default_nettype none

// SPI master for the MCP3008 with the data clock idling high
// one transaction is 17 data clock periods
//   periods 1-5   start, single ended, D2 D1 D0 driven on falling edges
//   periods 6-7   sample clock and null bit
//   periods 8-17  B9 down to B0 captured on rising edges
module mcp3008_interface #(
   parameter int DCLK_HALF = 4  // clk cycles per half data clock
) (
   input  wire logic                                clk,
   input  wire logic                                reset,
   input  wire logic                                adc_start,
   input  wire logic [2:0]                          adc_channel,
   input  wire logic                                mcp_dout,
   output logic                                     mcp_dclk,
   output logic                                     mcp_din,
   output logic                                     mcp_cs_n,
   output logic                                     adc_busy,
   output logic                                     adc_result_valid,
   output logic [camera_pkg::reply_width-1:0]       adc_result,
   input  wire logic                                adc_result_accept
);

   localparam int             DIV_W    = $clog2(DCLK_HALF + 1);
   localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(DCLK_HALF - 1);

   logic [DIV_W-1:0] div_cnt;
   logic [4:0]       period_cnt;   // 0 to 16
   logic [2:0]       channel;
   logic [8:0]       shift_reg;    // B9 to B1 while B0 comes straight from the pin
   logic             tick;         // data clock edge this cycle
   logic             last_period;
   logic             cmd_bit;

   assign tick        = adc_busy && (div_cnt == DIV_LAST);
   assign last_period = (period_cnt == 5'd16);

   always_comb begin
      case (period_cnt)
         5'd0:    cmd_bit = 1'b1; // start
         5'd1:    cmd_bit = 1'b1; // single ended
         5'd2:    cmd_bit = channel[2];
         5'd3:    cmd_bit = channel[1];
         5'd4:    cmd_bit = channel[0];
         default: cmd_bit = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         adc_busy         <= 1'b0;
         mcp_cs_n         <= 1'b1;
         mcp_dclk         <= 1'b1;
         mcp_din          <= 1'b0;
         adc_result_valid <= 1'b0;
         div_cnt          <= '0;
         period_cnt       <= 5'd0;
      end else begin
         if (adc_result_accept)
            adc_result_valid <= 1'b0;

         if (!adc_busy) begin
            if (adc_start) begin
               adc_busy   <= 1'b1;
               mcp_cs_n   <= 1'b0;
               div_cnt    <= '0;
               period_cnt <= 5'd0;
            end
         end else if (tick) begin
            div_cnt  <= '0;
            mcp_dclk <= ~mcp_dclk;
            if (mcp_dclk) begin
               mcp_din <= cmd_bit; // device latches this bit on the next rise
            end else if (last_period) begin
               adc_busy         <= 1'b0;
               mcp_cs_n         <= 1'b1;
               mcp_din          <= 1'b0;
               adc_result_valid <= 1'b1; // set wins over a same cycle accept
            end else begin
               period_cnt <= period_cnt + 5'd1;
            end
         end else begin
            div_cnt <= div_cnt + DIV_W'(1);
         end
      end
   end

   // channel, shift register and result
   always_ff @(posedge clk) begin
      if (!adc_busy && adc_start)
         channel <= adc_channel;
      if (tick && !mcp_dclk) begin
         if (period_cnt >= 5'd7)
            shift_reg <= {shift_reg[7:0], mcp_dout}; // MSB first
         if (last_period)
            adc_result <= {1'b0, channel, 2'b00, shift_reg, mcp_dout};
      end
   end

   // chip select must cover the whole busy window
   assert property (@(posedge clk) disable iff (reset) adc_busy |-> !mcp_cs_n);

endmodule

`default_nettype wire

//--- verilog/pwm_bank.sv
`timescale 1ns/1ps
`default_nettype none

// PWM_BITS is meant to lie between 8 and 16
module pwm_bank #(
   parameter int PWM_BITS = 8
) (
   input  wire logic       clk,
   input  wire logic       reset,
   input  wire logic [7:0] peltier_1_duty,
   input  wire logic [7:0] peltier_2_duty,
   input  wire logic       shutter_open,
   output logic            pwm_peltier_1,
   output logic            pwm_peltier_2,
   output logic            pwm_shutter
);

   logic [15:0]         counter;      // free running, shared by all channels
   logic [PWM_BITS-1:0] duty_1_ext;
   logic [PWM_BITS-1:0] duty_2_ext;
   logic [7:0]          shutter_duty;

   assign duty_1_ext = PWM_BITS'(peltier_1_duty);
   assign duty_2_ext = PWM_BITS'(peltier_2_duty);

   assign shutter_duty = shutter_open ? camera_pkg::shutter_open_duty
                                      : camera_pkg::shutter_closed_duty;

   always_ff @(posedge clk) begin
      if (reset)
         counter <= 16'h0000;
      else
         counter <= counter + 16'h0001;
   end

   // outputs registered so the pins carry no compare glitches
   always_ff @(posedge clk) begin
      if (reset) begin
         pwm_peltier_1 <= 1'b0;
         pwm_peltier_2 <= 1'b0;
         pwm_shutter   <= 1'b0;
      end else begin
         pwm_peltier_1 <= counter[PWM_BITS-1:0] < duty_1_ext;
         pwm_peltier_2 <= counter[PWM_BITS-1:0] < duty_2_ext;
         pwm_shutter   <= counter[15:8] < shutter_duty; // one pulse per 65536 cycles
      end
   end

endmodule

`default_nettype wire

//--- verilog/command_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module command_decoder (
   input  wire logic                                clk,
   input  wire logic                                reset,
   input  wire logic                                rx_strobe,
   input  wire logic [7:0]                          rx_data,
   input  wire logic                                adc_busy,
   input  wire logic                                readback_accept,
   output logic                                     adc_start,
   output logic [2:0]                               adc_channel,
   output logic                                     readback_valid,
   output logic [camera_pkg::reply_width-1:0]       readback_word,
   output logic [7:0]                               peltier_1_duty,
   output logic [7:0]                               peltier_2_duty,
   output logic                                     shutter_open
);

   typedef enum logic [2:0] {
      st_idle,
      st_set_addr,     // waiting for the register address
      st_set_value,    // waiting for the value byte
      st_read_addr,
      st_adc_channel
   } state_t;

   state_t     state;
   logic [1:0] wr_addr;    // address held between the two set bytes
   logic [7:0] spare_reg;
   logic [7:0] read_value;

   // register readback mux, unmapped address reads as zero
   always_comb begin
      case (rx_data[1:0])
         camera_pkg::reg_peltier_1: read_value = peltier_1_duty;
         camera_pkg::reg_peltier_2: read_value = peltier_2_duty;
         camera_pkg::reg_spare:     read_value = spare_reg;
         default:                   read_value = 8'h00;
      endcase
   end

   always_ff @(posedge clk) begin
      adc_start <= 1'b0; // single cycle strobe
      if (reset) begin
         state          <= st_idle;
         peltier_1_duty <= 8'h00;
         peltier_2_duty <= 8'h00;
         spare_reg      <= 8'h00;
         shutter_open   <= 1'b0;
         readback_valid <= 1'b0;
      end else begin
         if (readback_accept)
            readback_valid <= 1'b0;

         if (rx_strobe) begin
            case (state)
               st_idle: begin
                  case (rx_data)
                     camera_pkg::cmd_reset: begin
                        peltier_1_duty <= 8'h00;
                        peltier_2_duty <= 8'h00;
                        spare_reg      <= 8'h00;
                        shutter_open   <= 1'b0;
                     end
                     camera_pkg::cmd_open_shutter:  shutter_open <= 1'b1;
                     camera_pkg::cmd_close_shutter: shutter_open <= 1'b0;
                     camera_pkg::cmd_set_register:  state <= st_set_addr;
                     camera_pkg::cmd_read_register: state <= st_read_addr;
                     camera_pkg::cmd_sample_adc:    state <= st_adc_channel;
                     default:                       state <= st_idle; // unknown, ignore
                  endcase
               end
               st_set_addr: state <= st_set_value;
               st_set_value: begin
                  case (wr_addr)
                     camera_pkg::reg_peltier_1: peltier_1_duty <= rx_data;
                     camera_pkg::reg_peltier_2: peltier_2_duty <= rx_data;
                     camera_pkg::reg_spare:     spare_reg      <= rx_data;
                     default:                   ; // writes to address 3 are dropped
                  endcase
                  state <= st_idle;
               end
               st_read_addr: begin
                  readback_valid <= 1'b1; // a newer read replaces a pending one
                  state          <= st_idle;
               end
               st_adc_channel: begin
                  if (!adc_busy)
                     adc_start <= 1'b1;
                  state <= st_idle;
               end
               default: state <= st_idle;
            endcase
         end
      end
   end

   // payload side of the byte path
   always_ff @(posedge clk) begin
      if (rx_strobe && state == st_set_addr)
         wr_addr <= rx_data[1:0];
      if (rx_strobe && state == st_read_addr)
         readback_word <= {6'b000000, rx_data[1:0], read_value};
      if (rx_strobe && state == st_adc_channel)
         adc_channel <= rx_data[2:0];
   end

   // a conversion request must never reach the ADC interface mid transaction
   assert property (@(posedge clk) disable iff (reset) adc_start |-> !adc_busy);

endmodule

`default_nettype wire

//--- common/camera_pkg.sv
`default_nettype none

package camera_pkg;

   // width of every reply word sent to the host
   localparam int reply_width = 16;

   // host command codes
   localparam logic [7:0] cmd_reset         = 8'h01; // clear registers, close shutter
   localparam logic [7:0] cmd_open_shutter  = 8'h02;
   localparam logic [7:0] cmd_close_shutter = 8'h03;
   localparam logic [7:0] cmd_set_register  = 8'h04; // + address byte + value byte
   localparam logic [7:0] cmd_read_register = 8'h05; // + address byte
   localparam logic [7:0] cmd_sample_adc    = 8'h06; // + channel byte, low 3 bits

   // reply frame headers
   localparam logic [7:0] hdr_adc      = 8'hA1;
   localparam logic [7:0] hdr_register = 8'hA2;

   // settings register map, address 3 is unmapped
   localparam logic [1:0] reg_peltier_1 = 2'd0;
   localparam logic [1:0] reg_peltier_2 = 2'd1;
   localparam logic [1:0] reg_spare     = 2'd2;

   // shutter servo pulse widths, compared against the PWM counter upper byte
   localparam logic [7:0] shutter_open_duty   = 8'h50; // roughly 800 us
   localparam logic [7:0] shutter_closed_duty = 8'h96; // roughly 1500 us

endpackage

`default_nettype wire
